// ==== design/vtp_pkg.sv ====
package vtp_pkg;

    // ============================================================
    // Sizing
    // ============================================================

    // Byte offset bits within one 64 byte line
    localparam int LINE_BITS = 6;

    // Byte offset bits within one 4 KB page
    localparam int PAGE_BITS = 12;

    // Lines in a page, so a piece never covers more than this
    localparam int LINES_PER_PAGE = 64;

    // Direct mapped page table size
    localparam int PT_ENTRIES = 16;

    // Write data buffering, deep enough to cover the AW translation latency
    localparam int WFIFO_DEPTH = 32;

    // ============================================================
    // Types
    // ============================================================

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // Burst length in lines, minus one
    typedef logic [3:0] len_t;

    // Page numbers are the address bits above the page offset
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;

    // Low bits of the vpn select a table entry
    typedef logic [3:0] pt_idx_t;

    typedef logic [3:0] id_t;
    typedef logic [31:0] wdata_t;

endpackage

// ==== design/vtp_page_split.sv ====
`timescale 1ns/100ps

module vtp_page_split
    import vtp_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,

    input  logic   in_valid,
    output logic   in_ready,
    input  vaddr_t in_addr,
    input  len_t   in_len,
    input  id_t    in_id,

    output logic   out_valid,
    input  logic   out_ready,
    output vaddr_t out_addr,
    output len_t   out_len,
    output id_t    out_id,
    output logic   out_no_reply
);

    // Line counts need one bit more than len_t since a burst holds up to 16 lines
    typedef logic [$bits(len_t):0] lines_t;

    typedef enum logic {
        idle,
        emit
    } state_t;

    state_t state;

    // Current piece start, lines still to send and the tag of the request
    vaddr_t cur_addr;
    lines_t lines_left;
    id_t    cur_id;

    // Lines from the current address up to the end of its page range from 1 to 64
    logic [LINE_BITS:0] page_lines;
    lines_t             piece_lines;
    logic               last_piece;

    assign page_lines = (LINE_BITS + 1)'(LINES_PER_PAGE)
                        - {1'b0, cur_addr[PAGE_BITS-1:LINE_BITS]};

    // The burst ends in this page when its remaining lines fit
    assign last_piece = {{(LINE_BITS - $bits(lines_t) + 1){1'b0}}, lines_left} <= page_lines;

    // When the burst goes on past this page, the page remainder is below 16
    assign piece_lines = last_piece ? lines_left : lines_t'(page_lines);

    // New requests are only taken once every piece of the previous one has left
    assign in_ready = (state == idle);

    assign out_valid    = (state == emit);
    assign out_addr     = cur_addr;
    assign out_len      = len_t'(piece_lines - lines_t'(1));
    assign out_id       = cur_id;
    assign out_no_reply = !last_piece;

    // Control state
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= idle;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (in_valid)
                        state <= emit;
                end
                emit:
                begin
                    // Leave once the final piece has been taken
                    if (out_ready && last_piece)
                        state <= idle;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    // The request payload is loaded on accept and stepped one page per piece
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            cur_addr   <= in_addr;
            lines_left <= lines_t'(in_len) + lines_t'(1);
            cur_id     <= in_id;
        end
        else if (out_valid && out_ready && !last_piece)
        begin
            // Next piece starts on the following page boundary
            cur_addr   <= {cur_addr[$bits(vaddr_t)-1:PAGE_BITS] + vpn_t'(1),
                           {PAGE_BITS{1'b0}}};
            lines_left <= lines_left - piece_lines;
        end
    end

    // An emitted piece always has lines left and never runs past the end of its page
    a_piece_in_page: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (lines_left != '0)
                      && (({1'b0, out_addr[PAGE_BITS-1:LINE_BITS]}
                           + {{(LINE_BITS + 1 - $bits(len_t)){1'b0}}, out_len})
                          < (LINE_BITS + 1)'(LINES_PER_PAGE)));

endmodule

// ==== design/vtp_page_table.sv ====
`timescale 1ns/100ps

module vtp_page_table
    import vtp_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    // Programming port, loaded by the host before traffic starts
    input  logic pt_wr_en,
    input  vpn_t pt_vpn,
    input  ppn_t pt_ppn,

    // Read channel lookup
    input  vpn_t rd_vpn,
    output logic rd_hit,
    output ppn_t rd_ppn,

    // Write channel lookup
    input  vpn_t wr_vpn,
    output logic wr_hit,
    output ppn_t wr_ppn
);

    // Each entry keeps the full vpn as its tag so aliases on the index miss
    logic [PT_ENTRIES-1:0] entry_valid;
    vpn_t                  entry_tag [PT_ENTRIES];
    ppn_t                  entry_ppn [PT_ENTRIES];

    pt_idx_t pt_idx;
    pt_idx_t rd_idx;
    pt_idx_t wr_idx;

    assign pt_idx = pt_vpn[$bits(pt_idx_t)-1:0];
    assign rd_idx = rd_vpn[$bits(pt_idx_t)-1:0];
    assign wr_idx = wr_vpn[$bits(pt_idx_t)-1:0];

    // Valid bits start cleared so an empty table misses everywhere
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            entry_valid <= '0;
        else if (pt_wr_en)
            entry_valid[pt_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (pt_wr_en)
        begin
            entry_tag[pt_idx] <= pt_vpn;
            entry_ppn[pt_idx] <= pt_ppn;
        end
    end

    // Both lookups answer in the same cycle they are asked
    assign rd_hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_vpn);
    assign rd_ppn = entry_ppn[rd_idx];

    assign wr_hit = entry_valid[wr_idx] && (entry_tag[wr_idx] == wr_vpn);
    assign wr_ppn = entry_ppn[wr_idx];

endmodule

// ==== design/vtp_translate_chan.sv ====
`timescale 1ns/100ps

module vtp_translate_chan
    import vtp_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,

    // Page sized pieces from the splitter
    input  logic   piece_valid,
    output logic   piece_ready,
    input  vaddr_t piece_addr,
    input  len_t   piece_len,
    input  id_t    piece_id,
    input  logic   piece_no_reply,

    // Page table lookup, answered combinationally
    output vpn_t   lookup_vpn,
    input  logic   lookup_hit,
    input  ppn_t   lookup_ppn,

    // Translated requests toward the host
    output logic   host_valid,
    input  logic   host_ready,
    output paddr_t host_addr,
    output len_t   host_len,
    output id_t    host_id,
    output logic   host_no_reply,
    output logic   error
);

    // ============================================================
    // Two entry queue
    // ============================================================

    paddr_t q_addr     [2];
    len_t   q_len      [2];
    id_t    q_id       [2];
    logic   q_no_reply [2];
    logic   q_miss     [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    logic   push;
    logic   pop;
    paddr_t xlat_addr;

    assign piece_ready = (count != 2'd2);
    assign push        = piece_valid && piece_ready;
    assign pop         = host_valid && host_ready;

    // Look up the piece while it is being offered so the result lands with it
    assign lookup_vpn = piece_addr[$bits(vaddr_t)-1:PAGE_BITS];

    // A miss keeps the virtual address, the host side sees the error level
    assign xlat_addr = lookup_hit ? {lookup_ppn, piece_addr[PAGE_BITS-1:0]}
                                  : paddr_t'(piece_addr);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;

            // Push and pop in one cycle leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload, written only on accept
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q_addr[wr_ptr]     <= xlat_addr;
            q_len[wr_ptr]      <= piece_len;
            q_id[wr_ptr]       <= piece_id;
            q_no_reply[wr_ptr] <= piece_no_reply;
            q_miss[wr_ptr]     <= !lookup_hit;
        end
    end

    // ============================================================
    // Host side
    // ============================================================

    // The queue head is offered until the host takes it
    assign host_valid    = (count != 2'd0);
    assign host_addr     = q_addr[rd_ptr];
    assign host_len      = q_len[rd_ptr];
    assign host_id       = q_id[rd_ptr];
    assign host_no_reply = q_no_reply[rd_ptr];

    // Error follows the offered head only
    assign error = host_valid && q_miss[rd_ptr];

    // A stalled request must hold every field until the host accepts it
    a_host_stable: assert property (@(posedge clk) disable iff (!arst_n)
        host_valid && !host_ready |=>
            host_valid && $stable(host_addr) && $stable(host_len)
            && $stable(host_id) && $stable(host_no_reply) && $stable(error));

endmodule

// ==== design/vtp_wdata_fifo.sv ====
`timescale 1ns/100ps

module vtp_wdata_fifo
    import vtp_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,

    input  logic   in_valid,
    output logic   in_ready,
    input  wdata_t in_data,

    output logic   out_valid,
    input  logic   out_ready,
    output wdata_t out_data
);

    localparam int PTR_BITS = $clog2(WFIFO_DEPTH);

    wdata_t mem [WFIFO_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != (PTR_BITS + 1)'(WFIFO_DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= in_data;
    end

    // Data written this cycle shows at the head from the next one
    assign out_data = mem[rd_ptr];

    // A full FIFO has its pointers level and the count never runs past the depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (count <= (PTR_BITS + 1)'(WFIFO_DEPTH))
        && (count != (PTR_BITS + 1)'(WFIFO_DEPTH) || wr_ptr == rd_ptr));
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> (count != '0) && (wr_ptr != rd_ptr || count == (PTR_BITS + 1)'(WFIFO_DEPTH)));

endmodule

// ==== design/vtp_translate_axi.sv ====
`timescale 1ns/100ps

module vtp_translate_axi
    import vtp_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,

    // Accelerator side, virtual addresses
    input  logic   va_ar_valid,
    output logic   va_ar_ready,
    input  vaddr_t va_ar_addr,
    input  len_t   va_ar_len,
    input  id_t    va_ar_id,

    input  logic   va_aw_valid,
    output logic   va_aw_ready,
    input  vaddr_t va_aw_addr,
    input  len_t   va_aw_len,
    input  id_t    va_aw_id,

    input  logic   va_w_valid,
    output logic   va_w_ready,
    input  wdata_t va_w_data,

    // Host side, physical addresses
    output logic   host_ar_valid,
    input  logic   host_ar_ready,
    output paddr_t host_ar_addr,
    output len_t   host_ar_len,
    output id_t    host_ar_id,
    output logic   host_ar_no_reply,

    output logic   host_aw_valid,
    input  logic   host_aw_ready,
    output paddr_t host_aw_addr,
    output len_t   host_aw_len,
    output id_t    host_aw_id,
    output logic   host_aw_no_reply,

    output logic   host_w_valid,
    input  logic   host_w_ready,
    output wdata_t host_w_data,

    // Raised while a request that missed in the table is offered
    output logic   rd_error,
    output logic   wr_error,

    // Page table programming
    input  logic   pt_wr_en,
    input  vpn_t   pt_vpn,
    input  ppn_t   pt_ppn
);

    // ============================================================
    // Page splitting
    // ============================================================

    logic   ar_piece_valid;
    logic   ar_piece_ready;
    vaddr_t ar_piece_addr;
    len_t   ar_piece_len;
    id_t    ar_piece_id;
    logic   ar_piece_no_reply;

    logic   aw_piece_valid;
    logic   aw_piece_ready;
    vaddr_t aw_piece_addr;
    len_t   aw_piece_len;
    id_t    aw_piece_id;
    logic   aw_piece_no_reply;

    vtp_page_split ar_split (
        .clk, .arst_n,
        .in_valid(va_ar_valid), .in_ready(va_ar_ready), .in_addr(va_ar_addr),
        .in_len(va_ar_len), .in_id(va_ar_id),
        .out_valid(ar_piece_valid), .out_ready(ar_piece_ready),
        .out_addr(ar_piece_addr), .out_len(ar_piece_len), .out_id(ar_piece_id),
        .out_no_reply(ar_piece_no_reply)
    );

    vtp_page_split aw_split (
        .clk, .arst_n,
        .in_valid(va_aw_valid), .in_ready(va_aw_ready), .in_addr(va_aw_addr),
        .in_len(va_aw_len), .in_id(va_aw_id),
        .out_valid(aw_piece_valid), .out_ready(aw_piece_ready),
        .out_addr(aw_piece_addr), .out_len(aw_piece_len), .out_id(aw_piece_id),
        .out_no_reply(aw_piece_no_reply)
    );

    // ============================================================
    // Translation
    // ============================================================

    // Separate lookup ports since read and write streams are unrelated
    vpn_t ar_lookup_vpn;
    logic ar_lookup_hit;
    ppn_t ar_lookup_ppn;
    vpn_t aw_lookup_vpn;
    logic aw_lookup_hit;
    ppn_t aw_lookup_ppn;

    vtp_page_table page_table (
        .clk, .arst_n,
        .pt_wr_en, .pt_vpn, .pt_ppn,
        .rd_vpn(ar_lookup_vpn), .rd_hit(ar_lookup_hit), .rd_ppn(ar_lookup_ppn),
        .wr_vpn(aw_lookup_vpn), .wr_hit(aw_lookup_hit), .wr_ppn(aw_lookup_ppn)
    );

    vtp_translate_chan ar_chan (
        .clk, .arst_n,
        .piece_valid(ar_piece_valid), .piece_ready(ar_piece_ready),
        .piece_addr(ar_piece_addr), .piece_len(ar_piece_len),
        .piece_id(ar_piece_id), .piece_no_reply(ar_piece_no_reply),
        .lookup_vpn(ar_lookup_vpn), .lookup_hit(ar_lookup_hit), .lookup_ppn(ar_lookup_ppn),
        .host_valid(host_ar_valid), .host_ready(host_ar_ready), .host_addr(host_ar_addr),
        .host_len(host_ar_len), .host_id(host_ar_id), .host_no_reply(host_ar_no_reply),
        .error(rd_error)
    );

    vtp_translate_chan aw_chan (
        .clk, .arst_n,
        .piece_valid(aw_piece_valid), .piece_ready(aw_piece_ready),
        .piece_addr(aw_piece_addr), .piece_len(aw_piece_len),
        .piece_id(aw_piece_id), .piece_no_reply(aw_piece_no_reply),
        .lookup_vpn(aw_lookup_vpn), .lookup_hit(aw_lookup_hit), .lookup_ppn(aw_lookup_ppn),
        .host_valid(host_aw_valid), .host_ready(host_aw_ready), .host_addr(host_aw_addr),
        .host_len(host_aw_len), .host_id(host_aw_id), .host_no_reply(host_aw_no_reply),
        .error(wr_error)
    );

    // Write data is not translated, it only waits for the AW path
    vtp_wdata_fifo w_fifo (
        .clk, .arst_n,
        .in_valid(va_w_valid), .in_ready(va_w_ready), .in_data(va_w_data),
        .out_valid(host_w_valid), .out_ready(host_w_ready), .out_data(host_w_data)
    );

endmodule

// ==== bench/tb_vtp_translate.sv ====
`timescale 1ns/100ps

module tb_vtp_translate
    import vtp_pkg::*;
();

    // Longest wait in cycles for a single handshake and for the host side to drain
    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 20000;
    localparam int RANDOM_REQS = 300;
    localparam int RANDOM_BEATS = 600;

    // Mapped pages use table indices 0 to 9 while indices 10 to 15 stay empty
    localparam vpn_t MAP_BASE = 20'h00100;
    localparam int   MAPPED   = 10;

    // These pages share the indices of the mapped ones under another tag
    localparam vpn_t ALIAS_BASE = 20'h00300;

    typedef struct packed {
        logic   err;
        logic   no_reply;
        id_t    id;
        len_t   len;
        paddr_t addr;
    } piece_t;

    logic   clk;
    logic   arst_n;
    logic   va_ar_valid;
    logic   va_ar_ready;
    vaddr_t va_ar_addr;
    len_t   va_ar_len;
    id_t    va_ar_id;
    logic   va_aw_valid;
    logic   va_aw_ready;
    vaddr_t va_aw_addr;
    len_t   va_aw_len;
    id_t    va_aw_id;
    logic   va_w_valid;
    logic   va_w_ready;
    wdata_t va_w_data;
    logic   host_ar_valid;
    logic   host_ar_ready;
    paddr_t host_ar_addr;
    len_t   host_ar_len;
    id_t    host_ar_id;
    logic   host_ar_no_reply;
    logic   host_aw_valid;
    logic   host_aw_ready;
    paddr_t host_aw_addr;
    len_t   host_aw_len;
    id_t    host_aw_id;
    logic   host_aw_no_reply;
    logic   host_w_valid;
    logic   host_w_ready;
    wdata_t host_w_data;
    logic   rd_error;
    logic   wr_error;
    logic   pt_wr_en;
    vpn_t   pt_vpn;
    ppn_t   pt_ppn;

    // Model of the page table contents keyed by the full vpn
    ppn_t   page_map [vpn_t];
    piece_t exp_ar [$];
    piece_t exp_aw [$];
    wdata_t w_sent [$];
    wdata_t w_expected;

    int error_count;
    int timeout_count;
    int ar_checked;
    int aw_checked;
    int w_checked;
    int unsigned seed_ret;

    vtp_translate_axi dut0 (.*);

    always #5 clk = !clk;

    // ============================================================
    // Reference model
    // ============================================================

    // Splits one request into its expected host pieces and queues them per channel
    function automatic void predict_pieces(input logic is_write, input vaddr_t addr,
                                           input len_t len, input id_t id);
        vaddr_t cur;
        vpn_t   vpn;
        int     left;
        int     room;
        int     take;
        piece_t exp;
        cur  = addr;
        left = int'(len) + 1;
        while (left > 0)
        begin
            // A piece runs to the end of its page or to the end of the burst
            room = LINES_PER_PAGE - int'(cur[PAGE_BITS-1:LINE_BITS]);
            take = (left < room) ? left : room;
            vpn  = cur[31:PAGE_BITS];
            exp.id       = id;
            exp.len      = len_t'(take - 1);
            exp.no_reply = (left > take);
            if (page_map.exists(vpn))
            begin
                exp.err  = 1'b0;
                exp.addr = {page_map[vpn], cur[PAGE_BITS-1:0]};
            end
            else
            begin
                // A miss goes out with the virtual address as it was
                exp.err  = 1'b1;
                exp.addr = cur;
            end
            if (is_write)
                exp_aw.push_back(exp);
            else
                exp_ar.push_back(exp);
            left = left - take;
            cur  = {vpn + vpn_t'(1), {PAGE_BITS{1'b0}}};
        end
    endfunction

    function automatic vaddr_t random_addr();
        vpn_t                 vpn;
        int                   kind;
        logic [PAGE_BITS-1:0] offset;
        kind   = $urandom % 8;
        offset = PAGE_BITS'($urandom);
        if (kind < 5)
            vpn = MAP_BASE + vpn_t'($urandom % MAPPED);
        else if (kind < 7)
            vpn = ALIAS_BASE + vpn_t'($urandom % 16);
        else
            vpn = MAP_BASE + vpn_t'(MAPPED) + vpn_t'($urandom % 6);
        // Half the starts land near the page end so that many bursts cross it
        if ($urandom % 2)
            offset[PAGE_BITS-1:PAGE_BITS-3] = 3'b111;
        return {vpn, offset};
    endfunction

    // ============================================================
    // Run control and stimulus
    // ============================================================

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts; checked %0d ar, %0d aw, %0d w transfers",
                 error_count, timeout_count, ar_checked, aw_checked, w_checked);
        if (error_count == 0 && timeout_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout: gave up waiting for %s", what);
        finish_run();
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic send_addr(input logic is_write, input vaddr_t addr, input len_t len,
                             input id_t id);
        int waited;
        predict_pieces(is_write, addr, len, id);
        if (is_write)
        begin
            va_aw_valid = 1'b1;
            va_aw_addr  = addr;
            va_aw_len   = len;
            va_aw_id    = id;
        end
        else
        begin
            va_ar_valid = 1'b1;
            va_ar_addr  = addr;
            va_ar_len   = len;
            va_ar_id    = id;
        end
        waited = 0;
        while (!(is_write ? va_aw_ready : va_ar_ready) && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!(is_write ? va_aw_ready : va_ar_ready))
            report_timeout("an address request to be accepted");
        // Ready is registered, so the coming rising edge takes the request
        @(negedge clk);
        if (is_write)
            va_aw_valid = 1'b0;
        else
            va_ar_valid = 1'b0;
    endtask

    task automatic send_w(input wdata_t data);
        int waited;
        w_sent.push_back(data);
        va_w_valid = 1'b1;
        va_w_data  = data;
        waited = 0;
        while (!va_w_ready && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!va_w_ready)
            report_timeout("a write data beat to be accepted");
        @(negedge clk);
        va_w_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_ar.size() != 0 || exp_aw.size() != 0 || w_sent.size() != 0)
               && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_ar.size() != 0 || exp_aw.size() != 0 || w_sent.size() != 0)
            report_timeout("the host side to deliver every expected transfer");
        // A quiet stretch shows up any transfer beyond the expected ones
        repeat (20) @(negedge clk);
    endtask

    // Host back pressure with a separate rate per channel
    always @(negedge clk)
    begin
        host_ar_ready = ($urandom % 4) != 0;
        host_aw_ready = ($urandom % 3) != 0;
        host_w_ready  = ($urandom % 4) != 0;
    end

    // ============================================================
    // Compare processes
    // ============================================================

    task automatic check_host_piece(input logic is_write, input paddr_t addr, input len_t len,
                                    input id_t id, input logic no_reply, input logic err);
        piece_t exp;
        string  chan;
        int     pending;
        chan    = is_write ? "aw" : "ar";
        pending = is_write ? exp_aw.size() : exp_ar.size();
        assert (pending != 0)
        else
        begin
            error_count++;
            $display("Extra transfer on the host %s channel with no piece expected", chan);
        end
        if (pending != 0)
        begin
            if (is_write)
            begin
                exp = exp_aw.pop_front();
                aw_checked++;
            end
            else
            begin
                exp = exp_ar.pop_front();
                ar_checked++;
            end
            assert (addr == exp.addr)
            else
            begin
                error_count++;
                $display("Fail host_%s_addr: got %h, expected %h", chan, addr, exp.addr);
            end
            assert (len == exp.len)
            else
            begin
                error_count++;
                $display("Fail host_%s_len: got %h, expected %h", chan, len, exp.len);
            end
            assert (id == exp.id)
            else
            begin
                error_count++;
                $display("Fail host_%s_id: got %h, expected %h", chan, id, exp.id);
            end
            assert (no_reply == exp.no_reply)
            else
            begin
                error_count++;
                $display("Fail host_%s_no_reply: got %h, expected %h", chan, no_reply,
                         exp.no_reply);
            end
            assert (err == exp.err)
            else
            begin
                error_count++;
                $display("Fail %s: got %h, expected %h", is_write ? "wr_error" : "rd_error",
                         err, exp.err);
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            if (host_ar_valid && host_ar_ready)
                check_host_piece(1'b0, host_ar_addr, host_ar_len, host_ar_id,
                                 host_ar_no_reply, rd_error);
            assert (host_ar_valid || !rd_error)
            else
            begin
                error_count++;
                $display("rd_error is high while no read request is offered");
            end
        end
    end

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            if (host_aw_valid && host_aw_ready)
                check_host_piece(1'b1, host_aw_addr, host_aw_len, host_aw_id,
                                 host_aw_no_reply, wr_error);
            assert (host_aw_valid || !wr_error)
            else
            begin
                error_count++;
                $display("wr_error is high while no write request is offered");
            end
        end
    end

    // Write data must come out in the order it went in
    always @(posedge clk)
    begin
        if (arst_n && host_w_valid && host_w_ready)
        begin
            assert (w_sent.size() != 0)
            else
            begin
                error_count++;
                $display("Extra write data beat on the host side");
            end
            if (w_sent.size() != 0)
            begin
                w_expected = w_sent.pop_front();
                w_checked++;
                assert (host_w_data == w_expected)
                else
                begin
                    error_count++;
                    $display("Fail host_w_data: got %h, expected %h", host_w_data, w_expected);
                end
            end
        end
    end

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        seed_ret      = $urandom(44);
        clk           = 1'b0;
        arst_n        = 1'b0;
        va_ar_valid   = 1'b0;
        va_ar_addr    = '0;
        va_ar_len     = '0;
        va_ar_id      = '0;
        va_aw_valid   = 1'b0;
        va_aw_addr    = '0;
        va_aw_len     = '0;
        va_aw_id      = '0;
        va_w_valid    = 1'b0;
        va_w_data     = '0;
        host_ar_ready = 1'b0;
        host_aw_ready = 1'b0;
        host_w_ready  = 1'b0;
        pt_wr_en      = 1'b0;
        pt_vpn        = '0;
        pt_ppn        = '0;
        error_count   = 0;
        timeout_count = 0;
        ar_checked    = 0;
        aw_checked    = 0;
        w_checked     = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!host_ar_valid && !host_aw_valid && !host_w_valid && !rd_error && !wr_error)
        else
        begin
            error_count++;
            $display("A host valid or error level is high right after reset");
        end

        // Load the table one entry per cycle
        for (int i = 0; i < MAPPED; i++)
        begin
            pt_wr_en = 1'b1;
            pt_vpn   = MAP_BASE + vpn_t'(i);
            pt_ppn   = 20'hA5000 + ppn_t'(i * 17);
            page_map[pt_vpn] = pt_ppn;
            @(negedge clk);
        end
        pt_wr_en = 1'b0;

        // Bursts inside one page and then across a page end
        send_addr(1'b0, 32'h0010_0040, 4'd3, 4'h1);
        send_addr(1'b0, 32'h0010_1F80, 4'd7, 4'h2);
        send_addr(1'b0, 32'h0010_7FC4, 4'd15, 4'h3);
        // Empty index and aliased index followed by a mapped neighbour
        send_addr(1'b0, 32'h0010_C100, 4'd2, 4'h4);
        send_addr(1'b0, 32'h0030_5200, 4'd1, 4'h5);
        send_addr(1'b0, 32'h0010_5200, 4'd1, 4'h6);
        fork
            begin
                send_addr(1'b1, 32'h0010_3FC0, 4'd4, 4'h7);
                send_addr(1'b1, 32'h0030_2000, 4'd0, 4'h8);
                send_addr(1'b1, 32'h0010_2010, 4'd2, 4'h9);
            end
            begin
                for (int i = 0; i < 8; i++)
                    send_w(32'hC0DE_0000 + wdata_t'(i));
            end
        join
        wait_drained();

        // Several hundred requests per channel with random gaps
        fork
            repeat (RANDOM_REQS)
            begin
                repeat ($urandom % 3) @(negedge clk);
                send_addr(1'b0, random_addr(), len_t'($urandom), id_t'($urandom));
            end
            repeat (RANDOM_REQS)
            begin
                repeat ($urandom % 3) @(negedge clk);
                send_addr(1'b1, random_addr(), len_t'($urandom), id_t'($urandom));
            end
            repeat (RANDOM_BEATS)
            begin
                repeat ($urandom % 2) @(negedge clk);
                send_w(wdata_t'($urandom));
            end
        join
        wait_drained();
        finish_run();
    end

endmodule

// ==== sim.f ====
design/vtp_pkg.sv
design/vtp_page_split.sv
design/vtp_page_table.sv
design/vtp_translate_chan.sv
design/vtp_wdata_fifo.sv
design/vtp_translate_axi.sv
bench/tb_vtp_translate.sv
